// File: verilog.f
verilog/tcb_pkg.sv
verilog/tcb_reg.sv
verilog/tcb_dec.sv
verilog/tcb_mem.sv
verilog/tcb_gpio.sv
verilog/tcb_top.sv
testbench/tcb_assertions.sv
testbench/tcb_tb.sv

// File: Makefile
# Verilator build and run of the tcb testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for a pass"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -f verilog.f --top-module tcb_tb -Mdir obj_dir
	./obj_dir/Vtcb_tb +verilator+error+limit+100000 | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/tcb_tb.sv
`timescale 1ns/1ps

module tcb_tb;

  // requests per phase, they size the timeout
  localparam int N_FILL  = 16;
  localparam int N_MIX   = 40;
  localparam int N_UNMAP = 6;
  localparam int N_GLOOP = 4;
  localparam int N_PIPE  = 40;
  localparam int N_REQ   = N_FILL + N_MIX + N_UNMAP + 3 + 5 * N_GLOOP + N_PIPE;
  localparam int LIMIT   = 4 * N_REQ + 100;

  logic                       sub;
  logic                       reset;
  logic                       vld;
  logic                       wen;
  logic [tcb_pkg::BW-1:0]     ben;
  logic [tcb_pkg::AW-1:0]     adr;
  logic [tcb_pkg::DW-1:0]     wdt;
  logic [tcb_pkg::DW-1:0]     rdt;
  logic                       err;
  logic [tcb_pkg::GPIO_W-1:0] gpio_i;
  logic [tcb_pkg::GPIO_W-1:0] gpio_o;

  int cycles  = 0;
  int req_cnt = 0;

  tcb_top u_dut (
    .sub (sub), .reset (reset),
    .vld (vld), .wen (wen), .ben (ben), .adr (adr), .wdt (wdt),
    .rdt (rdt), .err (err),
    .gpio_i (gpio_i), .gpio_o (gpio_o)
  );

  // checker sees the top ports of the DUT
  bind tcb_top tcb_assertions u_chk (
    .sub (sub), .reset (reset),
    .vld (vld), .wen (wen), .ben (ben), .adr (adr), .wdt (wdt),
    .rdt (rdt), .err (err),
    .gpio_i (gpio_i), .gpio_o (gpio_o)
  );

  initial begin
    sub = 1'b0;
    forever #4 sub = ~sub;
  end

////////////////////////////////////////////////////////////////////////////
// request helpers
////////////////////////////////////////////////////////////////////////////

  task automatic issue(input logic w, input logic [tcb_pkg::BW-1:0] be,
                       input logic [tcb_pkg::AW-1:0] a, input logic [tcb_pkg::DW-1:0] d);
    @(posedge sub);
    vld <= 1'b1;
    wen <= w;
    ben <= be;
    adr <= a;
    wdt <= d;
    req_cnt++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge sub);
      vld <= 1'b0;
    end
  endtask

  // 16 slots spread 17 words apart over the whole array
  function automatic logic [tcb_pkg::AW-1:0] mem_adr(input int unsigned slot);
    return tcb_pkg::MEM_BASE + slot * 17 * tcb_pkg::BW;
  endfunction

  // addresses just outside each region, and far away
  function automatic logic [tcb_pkg::AW-1:0] unmapped_adr(input int unsigned pick);
    case (pick % 5)
      0:       return 32'h0000_0400;
      1:       return 32'h0001_0008;
      2:       return 32'h0000_fffc;
      3:       return 32'h8000_0000;
      default: return 32'hffff_fffc;
    endcase
  endfunction

  // 0/1 memory write/read, 2/3 gpio out write/read,
  // 4/5 gpio in read/write, anything else unmapped
  task automatic random_op(input int unsigned kind);
    logic [tcb_pkg::DW-1:0] d;
    logic [tcb_pkg::BW-1:0] be;
    int unsigned            pick;
    d    = $urandom;
    be   = d[tcb_pkg::BW-1:0];
    d    = $urandom;
    pick = $urandom % 16;
    case (kind)
      0:       issue(1'b1, be, mem_adr(pick), d);
      1:       issue(1'b0, be, mem_adr(pick), d);
      2:       issue(1'b1, be, tcb_pkg::GPIO_BASE + tcb_pkg::GPIO_OUT_OFS, d);
      3:       issue(1'b0, be, tcb_pkg::GPIO_BASE + tcb_pkg::GPIO_OUT_OFS, d);
      4:       issue(1'b0, be, tcb_pkg::GPIO_BASE + tcb_pkg::GPIO_IN_OFS, d);
      5:       issue(1'b1, be, tcb_pkg::GPIO_BASE + tcb_pkg::GPIO_IN_OFS, d);
      default: issue(d[31], be, unmapped_adr(pick), d);
    endcase
  endtask

////////////////////////////////////////////////////////////////////////////
// stimulus
////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hdc4b796b));
    reset  = 1'b1;
    vld    = 1'b0;
    wen    = 1'b0;
    ben    = '0;
    adr    = '0;
    wdt    = '0;
    gpio_i = '0;
    repeat (10) @(posedge sub);
    reset <= 1'b0;
    // quiet cycles so the reset check sees no traffic
    idle(2);
    // whole word writes give every slot a known value
    for (int s = 0; s < N_FILL; s++) begin
      issue(1'b1, '1, mem_adr(s), $urandom);
    end
    // partial writes and reads, back to back
    repeat (N_MIX) random_op($urandom % 2);
    idle(tcb_pkg::LAT);
    // full word writes to every unmapped address, then one read
    for (int u = 0; u < N_UNMAP; u++) begin
      issue(u < N_UNMAP - 1, '1, unmapped_adr(u), $urandom);
    end
    // gpio output and the memory words those addresses alias onto
    random_op(3);
    issue(1'b0, '1, mem_adr(0), '0);
    issue(1'b0, '1, mem_adr(N_FILL - 1), '0);
    idle(tcb_pkg::LAT);
    repeat (N_GLOOP) begin
      random_op(2);
      idle(3);
      random_op(3);
      // new pin value, held well past the synchroniser
      @(posedge sub);
      vld    <= 1'b0;
      gpio_i <= $urandom;
      idle(3);
      random_op(4);
      random_op(5);
      random_op(3);
    end
    idle(tcb_pkg::LAT);
    // everything mixed, up to LAT requests in flight
    repeat (N_PIPE) random_op($urandom % 7);
    idle(tcb_pkg::LAT + 2);
    $display("errors: %0d  requests: %0d  cycles: %0d",
             u_dut.u_chk.err_cnt, req_cnt, cycles);
    if (u_dut.u_chk.err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  always @(posedge sub) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, the stimulus did not complete", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

endmodule: tcb_tb

// File: testbench/tcb_assertions.sv
`timescale 1ns/1ps

module tcb_assertions (
  input logic                        sub,
  input logic                        reset,
  input logic                        vld,
  input logic                        wen,
  input logic [tcb_pkg::BW-1:0]      ben,
  input logic [tcb_pkg::AW-1:0]      adr,
  input logic [tcb_pkg::DW-1:0]      wdt,
  input logic [tcb_pkg::DW-1:0]      rdt,
  input logic                        err,
  input logic [tcb_pkg::GPIO_W-1:0]  gpio_i,
  input logic [tcb_pkg::GPIO_W-1:0]  gpio_o
);

  localparam int IW = $clog2(tcb_pkg::MEM_WORDS);

  int unsigned err_cnt = 0;

  // shadow state, written from requests seen at the top ports
  logic [tcb_pkg::DW-1:0]     shadow_mem [tcb_pkg::MEM_WORDS];
  logic [tcb_pkg::GPIO_W-1:0] shadow_out;
  // shadow output delayed to the cycle the pins change
  logic [tcb_pkg::GPIO_W-1:0] out_d1;

  // address map, offsets wrap so one compare covers each region
  logic [tcb_pkg::AW-1:0] off_mem;
  logic [tcb_pkg::AW-1:0] off_gpio;
  logic                   hit_mem;
  logic                   hit_gpio;
  logic [IW-1:0]          mem_idx;

  // prediction for the request in this cycle
  logic                   nxt_err;
  logic                   nxt_chk;
  logic [tcb_pkg::DW-1:0] nxt_rdt;
  // predictions in flight, index LAT-1 is due now
  logic                   pipe_err [tcb_pkg::LAT];
  logic                   pipe_chk [tcb_pkg::LAT];
  logic [tcb_pkg::DW-1:0] pipe_rdt [tcb_pkg::LAT];

  function automatic logic [tcb_pkg::DW-1:0] merge_bytes(
    input logic [tcb_pkg::DW-1:0] old_word,
    input logic [tcb_pkg::DW-1:0] new_word,
    input logic [tcb_pkg::BW-1:0] lanes
  );
    logic [tcb_pkg::DW-1:0] res;
    res = old_word;
    for (int b = 0; b < tcb_pkg::BW; b++) begin
      if (lanes[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign off_mem  = adr - tcb_pkg::MEM_BASE;
  assign off_gpio = adr - tcb_pkg::GPIO_BASE;
  assign hit_mem  = off_mem < tcb_pkg::MEM_WORDS * tcb_pkg::BW;
  // two word registers in the gpio block
  assign hit_gpio = off_gpio < tcb_pkg::GPIO_IN_OFS + tcb_pkg::BW;
  assign mem_idx  = IW'(off_mem / tcb_pkg::BW);

  always_comb begin
    nxt_err = vld && !hit_mem && !hit_gpio;
    // reads return data, unmapped accesses return zero
    nxt_chk = vld && (!wen || nxt_err);
    nxt_rdt = '0;
    if (vld && !wen && hit_mem) begin
      nxt_rdt = shadow_mem[mem_idx];
    end else if (vld && !wen && hit_gpio) begin
      nxt_rdt = (off_gpio == tcb_pkg::GPIO_IN_OFS) ? gpio_i : shadow_out;
    end
  end

////////////////////////////////////////////////////////////////////////////
// shadow model
////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sub) begin
    if (reset) begin
      shadow_out <= '0;
    end else if (vld && wen) begin
      if (hit_mem) begin
        shadow_mem[mem_idx] <= merge_bytes(shadow_mem[mem_idx], wdt, ben);
      end else if (hit_gpio && off_gpio == tcb_pkg::GPIO_OUT_OFS) begin
        shadow_out <= merge_bytes(shadow_out, wdt, ben);
      end
    end
  end

  always_ff @(posedge sub) begin
    if (reset) begin
      out_d1 <= '0;
      for (int i = 0; i < tcb_pkg::LAT; i++) begin
        pipe_err[i] <= 1'b0;
        pipe_chk[i] <= 1'b0;
        pipe_rdt[i] <= '0;
      end
    end else begin
      out_d1 <= shadow_out;
      pipe_err[0] <= nxt_err;
      pipe_chk[0] <= nxt_chk;
      pipe_rdt[0] <= nxt_rdt;
      for (int i = 1; i < tcb_pkg::LAT; i++) begin
        pipe_err[i] <= pipe_err[i-1];
        pipe_chk[i] <= pipe_chk[i-1];
        pipe_rdt[i] <= pipe_rdt[i-1];
      end
    end
  end

////////////////////////////////////////////////////////////////////////////
// checks
////////////////////////////////////////////////////////////////////////////

  // outputs clear in the first cycle out of reset
  a_reset: assert property (@(posedge sub) $fell(reset) |-> (err == 1'b0 && gpio_o == '0))
    else begin
      err_cnt++;
      $error("[FAIL] %0t gpio_o expected 0 actual %h, err expected 0 actual %b",
             $time, gpio_o, err);
    end

  // err tracks the address map LAT cycles after every request
  a_err: assert property (@(posedge sub) disable iff (reset)
    err == pipe_err[tcb_pkg::LAT-1])
    else begin
      err_cnt++;
      $error("[FAIL] %0t err expected %b actual %b", $time, pipe_err[tcb_pkg::LAT-1], err);
    end

  a_rdt: assert property (@(posedge sub) disable iff (reset)
    pipe_chk[tcb_pkg::LAT-1] |-> rdt == pipe_rdt[tcb_pkg::LAT-1])
    else begin
      err_cnt++;
      $error("[FAIL] %0t rdt expected %h actual %h", $time, pipe_rdt[tcb_pkg::LAT-1], rdt);
    end

  // pins trail the shadow register by the request stage
  a_gpio_o: assert property (@(posedge sub) disable iff (reset) gpio_o == out_d1)
    else begin
      err_cnt++;
      $error("[FAIL] %0t gpio_o expected %h actual %h", $time, out_d1, gpio_o);
    end

endmodule: tcb_assertions

// File: verilog/tcb_top.sv
`timescale 1ns/1ps

module tcb_top (
  input  logic                        sub,
  input  logic                        reset,
  // manager port
  input  logic                        vld,
  input  logic                        wen,
  input  logic [tcb_pkg::BW-1:0]      ben,
  input  logic [tcb_pkg::AW-1:0]      adr,
  input  logic [tcb_pkg::DW-1:0]      wdt,
  output logic [tcb_pkg::DW-1:0]      rdt,
  output logic                        err,
  // gpio pins
  input  logic [tcb_pkg::GPIO_W-1:0]  gpio_i,
  output logic [tcb_pkg::GPIO_W-1:0]  gpio_o
);

////////////////////////////////////////////////////////////////////////////
// internal bus between slice and decoder
////////////////////////////////////////////////////////////////////////////

  logic                   req_vld;
  logic                   req_wen;
  logic [tcb_pkg::BW-1:0] req_ben;
  logic [tcb_pkg::AW-1:0] req_adr;
  logic [tcb_pkg::DW-1:0] req_wdt;
  logic [tcb_pkg::DW-1:0] rsp_rdt;
  logic                   rsp_err;

  // per target strobes and read data
  logic                   mem_vld;
  logic                   gpio_vld;
  logic [tcb_pkg::DW-1:0] mem_rdt;
  logic [tcb_pkg::DW-1:0] gpio_rdt;

  // both paths registered, one cycle each way
  tcb_reg #(
    .CFG_REQ_REG (1'b1),
    .CFG_RSP_REG (1'b1)
  ) u_reg (
    .sub     (sub),      .reset   (reset),
    .sub_vld (vld),      .sub_wen (wen),     .sub_ben (ben),
    .sub_adr (adr),      .sub_wdt (wdt),
    .sub_rdt (rdt),      .sub_err (err),
    .man_vld (req_vld),  .man_wen (req_wen), .man_ben (req_ben),
    .man_adr (req_adr),  .man_wdt (req_wdt),
    .man_rdt (rsp_rdt),  .man_err (rsp_err)
  );

  tcb_dec u_dec (
    .sub      (sub),      .reset    (reset),
    .vld      (req_vld),  .wen      (req_wen),  .ben (req_ben),
    .adr      (req_adr),  .wdt      (req_wdt),
    .rdt      (rsp_rdt),  .err      (rsp_err),
    .mem_vld  (mem_vld),  .gpio_vld (gpio_vld),
    .mem_rdt  (mem_rdt),  .gpio_rdt (gpio_rdt)
  );

  // subordinates see the shared payload with their own strobe
  tcb_mem u_mem (
    .sub (sub),
    .vld (mem_vld),  .wen (req_wen),  .ben (req_ben),
    .adr (req_adr),  .wdt (req_wdt),  .rdt (mem_rdt)
  );

  tcb_gpio u_gpio (
    .sub    (sub),       .reset  (reset),
    .vld    (gpio_vld),  .wen    (req_wen),  .ben (req_ben),
    .adr    (req_adr),   .wdt    (req_wdt),  .rdt (gpio_rdt),
    .gpio_i (gpio_i),    .gpio_o (gpio_o)
  );

endmodule: tcb_top

// File: verilog/tcb_gpio.sv
`timescale 1ns/1ps

module tcb_gpio (
  input  logic                        sub,
  input  logic                        reset,
  // request, vld is the select strobe from the decoder
  input  logic                        vld,
  input  logic                        wen,
  input  logic [tcb_pkg::BW-1:0]      ben,
  input  logic [tcb_pkg::AW-1:0]      adr,
  input  logic [tcb_pkg::DW-1:0]      wdt,
  // read data, one cycle after the request
  output logic [tcb_pkg::DW-1:0]      rdt,
  // pins
  input  logic [tcb_pkg::GPIO_W-1:0]  gpio_i,
  output logic [tcb_pkg::GPIO_W-1:0]  gpio_o
);

  logic                       sel_out;
  logic                       sel_in;
  // two flop synchroniser on the asynchronous inputs
  logic [tcb_pkg::GPIO_W-1:0] gpio_meta;
  logic [tcb_pkg::GPIO_W-1:0] gpio_sync;

  // register select on the word offset inside the block
  assign sel_out = adr[tcb_pkg::GPIO_AW-1:tcb_pkg::AB]
                == tcb_pkg::GPIO_OUT_OFS[tcb_pkg::GPIO_AW-1:tcb_pkg::AB];
  assign sel_in  = adr[tcb_pkg::GPIO_AW-1:tcb_pkg::AB]
                == tcb_pkg::GPIO_IN_OFS[tcb_pkg::GPIO_AW-1:tcb_pkg::AB];

  always_ff @(posedge sub) begin
    gpio_meta <= gpio_i;
    gpio_sync <= gpio_meta;
  end

////////////////////////////////////////////////////////////////////////////
// output register
////////////////////////////////////////////////////////////////////////////

  // pins are driven low until software writes them
  always_ff @(posedge sub) begin
    if (reset) begin
      gpio_o <= '0;
    end else if (vld & wen & sel_out) begin
      for (int b = 0; b < tcb_pkg::BW; b++) begin
        if (ben[b]) begin
          gpio_o[8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  // read back, input register or current output value
  always_ff @(posedge sub) begin
    if (vld & ~wen) begin
      rdt <= sel_in ? gpio_sync : gpio_o;
    end
  end

endmodule: tcb_gpio

// File: verilog/tcb_mem.sv
`timescale 1ns/1ps

module tcb_mem (
  input  logic                    sub,
  // request, vld is the select strobe from the decoder
  input  logic                    vld,
  input  logic                    wen,
  input  logic [tcb_pkg::BW-1:0]  ben,
  input  logic [tcb_pkg::AW-1:0]  adr,
  input  logic [tcb_pkg::DW-1:0]  wdt,
  // read data, one cycle after the request
  output logic [tcb_pkg::DW-1:0]  rdt
);

////////////////////////////////////////////////////////////////////////////
// storage
////////////////////////////////////////////////////////////////////////////

  logic [tcb_pkg::DW-1:0] mem [tcb_pkg::MEM_WORDS];

  // word index, byte offset bits dropped
  logic [tcb_pkg::MEM_AW-tcb_pkg::AB-1:0] idx;

  // upper bits were already matched by the decoder
  assign idx = adr[tcb_pkg::MEM_AW-1:tcb_pkg::AB];

////////////////////////////////////////////////////////////////////////////
// write and read ports
////////////////////////////////////////////////////////////////////////////

  // byte lanes with a clear enable keep their old content
  always_ff @(posedge sub) begin
    if (vld & wen) begin
      for (int b = 0; b < tcb_pkg::BW; b++) begin
        if (ben[b]) begin
          mem[idx][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  // registered read, whole word regardless of the enables
  always_ff @(posedge sub) begin
    if (vld & ~wen) begin
      rdt <= mem[idx];
    end
  end

endmodule: tcb_mem

// File: verilog/tcb_dec.sv
`timescale 1ns/1ps

module tcb_dec (
  input  logic                    sub,
  input  logic                    reset,
  // request from the register slice
  input  logic                    vld,
  input  logic                    wen,
  input  logic [tcb_pkg::BW-1:0]  ben,
  input  logic [tcb_pkg::AW-1:0]  adr,
  input  logic [tcb_pkg::DW-1:0]  wdt,
  // response towards the register slice
  output logic [tcb_pkg::DW-1:0]  rdt,
  output logic                    err,
  // target select strobes, payload is shared
  output logic                    mem_vld,
  output logic                    gpio_vld,
  // target read data
  input  logic [tcb_pkg::DW-1:0]  mem_rdt,
  input  logic [tcb_pkg::DW-1:0]  gpio_rdt
);

////////////////////////////////////////////////////////////////////////////
// address decode
////////////////////////////////////////////////////////////////////////////

  logic       hit_mem;
  logic       hit_gpio;
  // selection bits: [0] memory, [1] gpio, [2] unmapped, [3] read
  logic [3:0] sel;
  // selection delayed to line up with the returning read data
  logic [3:0] sel_q [tcb_pkg::DLY];
  logic [3:0] sel_r;

  // compare the bits above each region's span against its base
  assign hit_mem  = adr[tcb_pkg::AW-1:tcb_pkg::MEM_AW]
                 == tcb_pkg::MEM_BASE[tcb_pkg::AW-1:tcb_pkg::MEM_AW];
  assign hit_gpio = adr[tcb_pkg::AW-1:tcb_pkg::GPIO_AW]
                 == tcb_pkg::GPIO_BASE[tcb_pkg::AW-1:tcb_pkg::GPIO_AW];

  // at most one strobe, regions do not overlap
  assign mem_vld  = vld & hit_mem;
  assign gpio_vld = vld & hit_gpio;

  assign sel[0] = mem_vld;
  assign sel[1] = gpio_vld;
  // nothing answers this one, so the decoder does
  assign sel[2] = vld & ~hit_mem & ~hit_gpio;
  assign sel[3] = vld & ~wen;

////////////////////////////////////////////////////////////////////////////
// response tracking
////////////////////////////////////////////////////////////////////////////

  // DLY deep shift of the selection, cleared so err starts low
  always_ff @(posedge sub) begin
    if (reset) begin
      for (int i = 0; i < tcb_pkg::DLY; i++) begin
        sel_q[i] <= '0;
      end
    end else begin
      sel_q[0] <= sel;
      for (int i = 1; i < tcb_pkg::DLY; i++) begin
        sel_q[i] <= sel_q[i-1];
      end
    end
  end

  assign sel_r = sel_q[tcb_pkg::DLY-1];

  // data mux, zero for writes and unmapped accesses
  always_comb begin
    rdt = '0;
    if (sel_r[3]) begin
      if (sel_r[0]) begin
        rdt = mem_rdt;
      end else if (sel_r[1]) begin
        rdt = gpio_rdt;
      end
    end
  end

  // error for unmapped reads and writes alike
  assign err = sel_r[2];

endmodule: tcb_dec

// File: verilog/tcb_reg.sv
`timescale 1ns/1ps

module tcb_reg #(
  // register the request path
  parameter bit CFG_REQ_REG = 1'b1,
  // register the response path
  parameter bit CFG_RSP_REG = 1'b1
)(
  input  logic                    sub,
  input  logic                    reset,
  // subordinate side, the manager connects here
  input  logic                    sub_vld,
  input  logic                    sub_wen,
  input  logic [tcb_pkg::BW-1:0]  sub_ben,
  input  logic [tcb_pkg::AW-1:0]  sub_adr,
  input  logic [tcb_pkg::DW-1:0]  sub_wdt,
  output logic [tcb_pkg::DW-1:0]  sub_rdt,
  output logic                    sub_err,
  // manager side, the decoder connects here
  output logic                    man_vld,
  output logic                    man_wen,
  output logic [tcb_pkg::BW-1:0]  man_ben,
  output logic [tcb_pkg::AW-1:0]  man_adr,
  output logic [tcb_pkg::DW-1:0]  man_wdt,
  input  logic [tcb_pkg::DW-1:0]  man_rdt,
  input  logic                    man_err
);

////////////////////////////////////////////////////////////////////////////
// request path
////////////////////////////////////////////////////////////////////////////

  if (CFG_REQ_REG) begin: gen_req_reg
    // only the valid needs a defined value out of reset
    always_ff @(posedge sub) begin
      if (reset) begin
        man_vld <= 1'b0;
      end else begin
        man_vld <= sub_vld;
      end
    end

    // payload follows the valid one cycle late
    always_ff @(posedge sub) begin
      man_wen <= sub_wen;
      man_ben <= sub_ben;
      man_adr <= sub_adr;
      man_wdt <= sub_wdt;
    end
  end: gen_req_reg
  else begin: gen_req_cmb
    assign man_vld = sub_vld;
    assign man_wen = sub_wen;
    assign man_ben = sub_ben;
    assign man_adr = sub_adr;
    assign man_wdt = sub_wdt;
  end: gen_req_cmb

////////////////////////////////////////////////////////////////////////////
// response path
////////////////////////////////////////////////////////////////////////////

  if (CFG_RSP_REG) begin: gen_rsp_reg
    // error bit low out of reset, data free running
    always_ff @(posedge sub) begin
      if (reset) begin
        sub_err <= 1'b0;
      end else begin
        sub_err <= man_err;
      end
    end

    always_ff @(posedge sub) begin
      sub_rdt <= man_rdt;
    end
  end: gen_rsp_reg
  else begin: gen_rsp_cmb
    assign sub_rdt = man_rdt;
    assign sub_err = man_err;
  end: gen_rsp_cmb

endmodule: tcb_reg

// File: verilog/tcb_pkg.sv
////////////////////////////////////////////////////////////////////////////
// bus geometry
////////////////////////////////////////////////////////////////////////////

package tcb_pkg;

  // address, data and byte enable widths
  localparam int unsigned AW = 32;
  localparam int unsigned DW = 32;
  localparam int unsigned BW = DW / 8;
  // number of byte offset bits inside a word
  localparam int unsigned AB = $clog2(BW);

  // read delay of every subordinate, in cycles
  localparam int unsigned DLY = 1;

  //////////////////////////////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////////////////////////////

  // word memory, 0x0000_0000 .. 0x0000_03ff
  localparam logic [AW-1:0] MEM_BASE  = 32'h0000_0000;
  localparam int unsigned   MEM_WORDS = 256;
  // byte address bits covered by the memory region
  localparam int unsigned   MEM_AW    = $clog2(MEM_WORDS) + AB;

  // gpio block, two word registers
  localparam logic [AW-1:0] GPIO_BASE    = 32'h0001_0000;
  localparam logic [AW-1:0] GPIO_OUT_OFS = 32'h0000_0000;
  // input register, read only, writes are dropped silently
  localparam logic [AW-1:0] GPIO_IN_OFS  = 32'h0000_0004;
  // byte address bits covered by the gpio region
  localparam int unsigned   GPIO_AW      = $clog2(int'(GPIO_IN_OFS) + BW);
  localparam int unsigned   GPIO_W       = 32;

  // top level latency: request stage, subordinate read, response stage
  localparam int unsigned LAT = 1 + DLY + 1;

endpackage: tcb_pkg
